//--- rtl/mult_cfg.svh
`ifndef MULT_CFG_SVH
`define MULT_CFG_SVH

// operand and product width
`define MULT_WORD_WIDTH 64
// partial-product stages, each consumes one digit of the multiplier
`define MULT_STAGES 8
// immediate operand width
`define MULT_LITERAL_WIDTH 8
// reorder buffer entries
`define MULT_ROB_DEPTH 32
// physical registers
`define MULT_PR_COUNT 64

`endif

//--- rtl/mult_complete.sv
module mult_complete (
  input  logic                clock,
  input  logic                reset,
  input  logic                rollback_en,
  input  mult_pkg::rob_idx_t  rollback_idx,
  input  mult_pkg::rob_idx_t  rob_tail_idx,
  input  logic                cdb_grant,
  mult_stage_if.downstream    in,
  output logic                done,
  output mult_pkg::word_t     result,
  output mult_pkg::pr_idx_t   done_t_idx,
  output mult_pkg::rob_idx_t  done_rob_idx
);
  import mult_pkg::*;

  logic free;
  logic load;
  logic squash_in;
  logic squash_held;

  // the CDB grant frees the slot in the same cycle
  assign free = !done || cdb_grant;
  assign in.advance = free;
  assign load = in.occupied && free;

  assign squash_in = rollback_en && rob_squashed(in.rob_idx, rollback_idx, rob_tail_idx);
  assign squash_held = rollback_en && rob_squashed(done_rob_idx, rollback_idx, rob_tail_idx);

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (load) begin
      done <= !squash_in;
    end else if (cdb_grant || squash_held) begin
      done <= 1'b0;
    end
  end

  // last stage already holds the full low-word sum
  always_ff @(posedge clock) begin
    if (load) begin
      result <= in.product;
      done_t_idx <= in.t_idx;
      done_rob_idx <= in.rob_idx;
    end
  end

  // result waits on the bus unchanged until granted
  held_result_a: assert property (@(posedge clock) disable iff (reset)
    (done && !cdb_grant && !rollback_en) |=>
      (done && $stable(result) && $stable(done_t_idx) && $stable(done_rob_idx)));

endmodule

//--- rtl/mult_issue.sv
`include "mult_cfg.svh"

module mult_issue (
  input  logic                clock,
  input  logic                reset,
  input  logic                issue,
  input  mult_pkg::word_t     t1_value,
  input  mult_pkg::word_t     t2_value,
  input  mult_pkg::literal_t  literal,
  input  logic                use_literal,
  input  mult_pkg::pr_idx_t   t_idx,
  input  mult_pkg::rob_idx_t  rob_idx,
  input  logic                rollback_en,
  input  mult_pkg::rob_idx_t  rollback_idx,
  input  mult_pkg::rob_idx_t  rob_tail_idx,
  output logic                issue_ready,
  mult_stage_if.upstream      out
);
  import mult_pkg::*;

  logic     occupied;
  word_t    slot_mplier;
  word_t    slot_mcand;
  pr_idx_t  slot_t_idx;
  rob_idx_t slot_rob_idx;
  logic     accept;
  logic     squash_slot;

  // free when empty or when the held entry moves on
  assign issue_ready = !occupied || out.advance;

  // a request that is itself rolled back never enters
  assign accept = issue && issue_ready &&
                  !(rollback_en && rob_squashed(rob_idx, rollback_idx, rob_tail_idx));
  assign squash_slot = rollback_en && rob_squashed(slot_rob_idx, rollback_idx, rob_tail_idx);

  always_ff @(posedge clock) begin
    if (reset) begin
      occupied <= 1'b0;
    end else if (accept) begin
      occupied <= 1'b1;
    end else if (out.advance || squash_slot) begin
      occupied <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      slot_mplier <= t1_value;
      // literal is zero-extended
      slot_mcand <= use_literal ?
                    {{(`MULT_WORD_WIDTH-`MULT_LITERAL_WIDTH){1'b0}}, literal} : t2_value;
      slot_t_idx <= t_idx;
      slot_rob_idx <= rob_idx;
    end
  end

  assign out.occupied = occupied;
  assign out.product = '0;
  assign out.mplier = slot_mplier;
  assign out.mcand = slot_mcand;
  assign out.t_idx = slot_t_idx;
  assign out.rob_idx = slot_rob_idx;

  // a stalled entry keeps its operands and tags
  slot_held_a: assert property (@(posedge clock) disable iff (reset)
    (occupied && !out.advance && !squash_slot) |=>
      (occupied && $stable(slot_mplier) && $stable(slot_mcand) && $stable(slot_rob_idx)));

endmodule

//--- rtl/mult_pipeline.sv
`include "mult_cfg.svh"

module mult_pipeline (
  input  logic                clock,
  input  logic                reset,
  input  logic                rollback_en,
  input  mult_pkg::rob_idx_t  rollback_idx,
  input  mult_pkg::rob_idx_t  rob_tail_idx,
  mult_stage_if.downstream    in,
  mult_stage_if.upstream      out
);

  // links between neighbouring stages
  mult_stage_if link [`MULT_STAGES-1] ();

  for (genvar k = 0; k < `MULT_STAGES; k++) begin : g_stage
    if (k == 0) begin : g_first
      mult_stage stage_inst (
        .clock        (clock),
        .reset        (reset),
        .rollback_en  (rollback_en),
        .rollback_idx (rollback_idx),
        .rob_tail_idx (rob_tail_idx),
        .in           (in),
        .out          (link[0])
      );
    end else if (k == `MULT_STAGES - 1) begin : g_last
      mult_stage stage_inst (
        .clock        (clock),
        .reset        (reset),
        .rollback_en  (rollback_en),
        .rollback_idx (rollback_idx),
        .rob_tail_idx (rob_tail_idx),
        .in           (link[k-1]),
        .out          (out)
      );
    end else begin : g_mid
      mult_stage stage_inst (
        .clock        (clock),
        .reset        (reset),
        .rollback_en  (rollback_en),
        .rollback_idx (rollback_idx),
        .rob_tail_idx (rob_tail_idx),
        .in           (link[k-1]),
        .out          (link[k])
      );
    end
  end

endmodule

//--- rtl/mult_pkg.sv
`include "mult_cfg.svh"

package mult_pkg;

  // operand, multiplicand, multiplier or product
  typedef logic [`MULT_WORD_WIDTH-1:0] word_t;
  // multiplier slice consumed by one stage
  typedef logic [`MULT_WORD_WIDTH/`MULT_STAGES-1:0] digit_t;
  typedef logic [`MULT_LITERAL_WIDTH-1:0] literal_t;
  typedef logic [$clog2(`MULT_ROB_DEPTH)-1:0] rob_idx_t;
  typedef logic [$clog2(`MULT_PR_COUNT)-1:0] pr_idx_t;

  // true when the entry lies between the rollback point and the tail,
  // both distances taken modulo the ROB depth
  function automatic logic rob_squashed(
    input rob_idx_t entry_idx,
    input rob_idx_t rollback_idx,
    input rob_idx_t tail_idx
  );
    rob_idx_t entry_dist;
    rob_idx_t tail_dist;
    entry_dist = entry_idx - rollback_idx;
    tail_dist = tail_idx - rollback_idx;
    return entry_dist <= tail_dist;
  endfunction

endpackage

//--- rtl/mult_stage.sv
`include "mult_cfg.svh"

module mult_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                rollback_en,
  input  mult_pkg::rob_idx_t  rollback_idx,
  input  mult_pkg::rob_idx_t  rob_tail_idx,
  mult_stage_if.downstream    in,
  mult_stage_if.upstream      out
);
  import mult_pkg::*;

  localparam int DIGIT_WIDTH = `MULT_WORD_WIDTH / `MULT_STAGES;

  logic     occupied;
  word_t    product;
  word_t    mplier;
  word_t    mcand;
  pr_idx_t  t_idx;
  rob_idx_t rob_idx;
  logic     free;
  logic     load;
  logic     squash_in;
  logic     squash_held;
  digit_t   digit;
  word_t    partial;

  // empty, or the current entry leaves this edge
  assign free = !occupied || out.advance;
  assign in.advance = free;
  assign load = in.occupied && free;

  assign squash_in = rollback_en && rob_squashed(in.rob_idx, rollback_idx, rob_tail_idx);
  assign squash_held = rollback_en && rob_squashed(rob_idx, rollback_idx, rob_tail_idx);

  // low digit of the incoming multiplier against the shifted multiplicand
  assign digit = in.mplier[DIGIT_WIDTH-1:0];
  assign partial = digit * in.mcand;

  always_ff @(posedge clock) begin
    if (reset) begin
      occupied <= 1'b0;
    end else if (load) begin
      occupied <= !squash_in;
    end else if (out.advance || squash_held) begin
      occupied <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      product <= in.product + partial;
      mplier <= in.mplier >> DIGIT_WIDTH;
      mcand <= in.mcand << DIGIT_WIDTH;
      t_idx <= in.t_idx;
      rob_idx <= in.rob_idx;
    end
  end

  assign out.occupied = occupied;
  assign out.product = product;
  assign out.mplier = mplier;
  assign out.mcand = mcand;
  assign out.t_idx = t_idx;
  assign out.rob_idx = rob_idx;

  // the stage comes out of reset empty
  reset_empty_a: assert property (@(posedge clock) reset |=> !out.occupied);

endmodule

//--- rtl/mult_stage_if.sv
`include "mult_cfg.svh"

interface mult_stage_if;
  import mult_pkg::*;

  // entry valid at the upstream position
  logic occupied;
  // partial sum so far
  word_t product;
  // multiplier with consumed digits shifted out
  word_t mplier;
  // multiplicand shifted left to match
  word_t mcand;
  pr_idx_t t_idx;
  rob_idx_t rob_idx;
  // downstream takes the entry at the next edge
  logic advance;

  modport upstream (
    output occupied, product, mplier, mcand, t_idx, rob_idx,
    input advance
  );

  modport downstream (
    input occupied, product, mplier, mcand, t_idx, rob_idx,
    output advance
  );

endinterface

//--- rtl/mult_unit.sv
module mult_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                issue,
  input  mult_pkg::word_t     t1_value,
  input  mult_pkg::word_t     t2_value,
  input  mult_pkg::literal_t  literal,
  input  logic                use_literal,
  input  mult_pkg::pr_idx_t   t_idx,
  input  mult_pkg::rob_idx_t  rob_idx,
  input  logic                rollback_en,
  input  mult_pkg::rob_idx_t  rollback_idx,
  input  mult_pkg::rob_idx_t  rob_tail_idx,
  input  logic                cdb_grant,
  output logic                issue_ready,
  output logic                done,
  output mult_pkg::word_t     result,
  output mult_pkg::pr_idx_t   done_t_idx,
  output mult_pkg::rob_idx_t  done_rob_idx
);

  mult_stage_if issue_link ();
  mult_stage_if done_link ();

  mult_issue issue_inst (
    .clock        (clock),
    .reset        (reset),
    .issue        (issue),
    .t1_value     (t1_value),
    .t2_value     (t2_value),
    .literal      (literal),
    .use_literal  (use_literal),
    .t_idx        (t_idx),
    .rob_idx      (rob_idx),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .rob_tail_idx (rob_tail_idx),
    .issue_ready  (issue_ready),
    .out          (issue_link)
  );

  // eight partial-product steps
  mult_pipeline pipeline_inst (
    .clock        (clock),
    .reset        (reset),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .rob_tail_idx (rob_tail_idx),
    .in           (issue_link),
    .out          (done_link)
  );

  mult_complete complete_inst (
    .clock        (clock),
    .reset        (reset),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .rob_tail_idx (rob_tail_idx),
    .cdb_grant    (cdb_grant),
    .in           (done_link),
    .done         (done),
    .result       (result),
    .done_t_idx   (done_t_idx),
    .done_rob_idx (done_rob_idx)
  );

endmodule

//--- sim.f
+incdir+rtl
rtl/mult_pkg.sv
rtl/mult_stage_if.sv
rtl/mult_issue.sv
rtl/mult_stage.sv
rtl/mult_pipeline.sv
rtl/mult_complete.sv
rtl/mult_unit.sv
verification/mult_unit_tb.sv

//--- verification/mult_unit_tb.sv
`include "mult_cfg.svh"

module mult_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import mult_pkg::*;

  // directed, back-to-back, back-pressure, random-grant and rollback operations
  localparam int TOTAL_OPS = 116;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_OPS + 200;

  typedef struct {
    word_t    product;
    pr_idx_t  t_idx;
    rob_idx_t rob_idx;
  } expect_t;

  logic     clock;
  logic     reset;
  logic     issue;
  word_t    t1_value;
  word_t    t2_value;
  literal_t literal;
  logic     use_literal;
  pr_idx_t  t_idx;
  rob_idx_t rob_idx;
  logic     rollback_en;
  rob_idx_t rollback_idx;
  rob_idx_t rob_tail_idx;
  logic     cdb_grant;
  logic     issue_ready;
  logic     done;
  word_t    result;
  pr_idx_t  done_t_idx;
  rob_idx_t done_rob_idx;

  expect_t exp_q[$];
  logic [63:0] rng_state = 64'd76;
  rob_idx_t rob_next = '0;
  // 0 grant always, 1 random grant, 2 grant withheld
  int grant_mode = 0;
  int cycle_count = 0;

  mult_unit mult_unit_inst (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [63:0] xorshift64(input logic [63:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  function automatic logic [63:0] random_word();
    rng_state = xorshift64(rng_state);
    return rng_state;
  endfunction

  // low word of the product, literal zero-extended
  function automatic word_t ref_product(input word_t a, input word_t b, input literal_t lit,
                                        input logic lit_sel);
    word_t opb;
    opb = lit_sel ? word_t'(lit) : b;
    return a * opb;
  endfunction

  // distance from the rollback point, modulo ROB depth
  function automatic logic squashed_by_rollback(input int entry, input int rb, input int tail);
    int entry_dist;
    int tail_dist;
    entry_dist = (entry - rb + `MULT_ROB_DEPTH) % `MULT_ROB_DEPTH;
    tail_dist = (tail - rb + `MULT_ROB_DEPTH) % `MULT_ROB_DEPTH;
    return entry_dist <= tail_dist;
  endfunction

  task automatic report_failure();
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic step();
    @(posedge clock);
    #10;
    case (grant_mode)
      0: cdb_grant = 1'b1;
      1: cdb_grant = random_word() >> 63;
      default: cdb_grant = 1'b0;
    endcase
  endtask

  task automatic send_op(input word_t a, input word_t b, input literal_t lit,
                         input logic lit_sel);
    logic ok;
    issue = 1'b1;
    t1_value = a;
    t2_value = b;
    literal = lit;
    use_literal = lit_sel;
    t_idx = pr_idx_t'(random_word());
    rob_idx = rob_next;
    do begin
      @(negedge clock);
      ok = issue_ready;
      step();
    end while (!ok);
    issue = 1'b0;
    rob_next = rob_next + 1'b1;
  endtask

  task automatic send_random_op();
    logic [63:0] sel;
    sel = random_word();
    send_op(random_word(), random_word() >> sel[5:0], literal_t'(sel >> 8), sel[63]);
  endtask

  // a same-edge request tagged at the rollback point must not enter
  task automatic do_rollback(input rob_idx_t rb, input rob_idx_t tail);
    rollback_en = 1'b1;
    rollback_idx = rb;
    rob_tail_idx = tail;
    issue = 1'b1;
    t1_value = random_word();
    t2_value = random_word();
    use_literal = 1'b0;
    rob_idx = rb;
    step();
    rollback_en = 1'b0;
    issue = 1'b0;
    rob_next = rb;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || done) step();
  endtask

  task automatic check_latency();
    int n;
    n = 0;
    @(negedge clock);
    while (!done && n < 20) begin
      n++;
      @(negedge clock);
    end
    assert (n == 9) else begin
      $display("Error: done latency expected 0x%h got 0x%h", 9, n);
      report_failure();
    end
    step();
  endtask

  // scoreboard, evaluated mid-cycle for the coming edge
  always @(negedge clock) begin : scoreboard
    expect_t head;
    expect_t entry;
    int i;
    if (!reset) begin
      if (done && cdb_grant) begin
        assert (exp_q.size() != 0) else begin
          $display("DUT delivered a result while no multiply was pending");
          report_failure();
        end
        head = exp_q.pop_front();
        assert (result === head.product) else begin
          $display("Error: result expected 0x%h got 0x%h", head.product, result);
          report_failure();
        end
        assert (done_t_idx === head.t_idx) else begin
          $display("Error: done_t_idx expected 0x%h got 0x%h", head.t_idx, done_t_idx);
          report_failure();
        end
        assert (done_rob_idx === head.rob_idx) else begin
          $display("Error: done_rob_idx expected 0x%h got 0x%h", head.rob_idx, done_rob_idx);
          report_failure();
        end
      end
      if (rollback_en) begin
        for (i = exp_q.size() - 1; i >= 0; i--) begin
          if (squashed_by_rollback(exp_q[i].rob_idx, rollback_idx, rob_tail_idx))
            exp_q.delete(i);
        end
      end
      if (issue && issue_ready &&
          !(rollback_en && squashed_by_rollback(rob_idx, rollback_idx, rob_tail_idx))) begin
        entry.product = ref_product(t1_value, t2_value, literal, use_literal);
        entry.t_idx = t_idx;
        entry.rob_idx = rob_idx;
        exp_q.push_back(entry);
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the multiplies did not all complete within %0d cycles", cycle_count);
      report_failure();
    end
  end

  initial begin
    reset = 1'b1;
    issue = 1'b0;
    t1_value = '0;
    t2_value = '0;
    literal = '0;
    use_literal = 1'b0;
    t_idx = '0;
    rob_idx = '0;
    rollback_en = 1'b0;
    rollback_idx = '0;
    rob_tail_idx = '0;
    cdb_grant = 1'b1;
    repeat (5) step();
    reset = 1'b0;

    @(negedge clock);
    assert (issue_ready && !done) else begin
      $display("After reset the unit is not idle and ready");
      report_failure();
    end
    step();

    // single multiplies, latency checked
    send_op(64'd0, 64'h1234_5678_9abc_def0, 8'h00, 1'b0);
    check_latency();
    send_op('1, '1, 8'h00, 1'b0);
    check_latency();
    send_op(64'h8000_0000_0000_0000, 64'd3, 8'h00, 1'b0);
    check_latency();
    send_op(64'hffff_0000_1234_5678, 64'hdead_beef_0000_0001, 8'h00, 1'b0);
    check_latency();
    send_op(64'hf0f0_f0f0_f0f0_f0f1, 64'd0, 8'hff, 1'b1);
    check_latency();

    repeat (40) send_random_op();
    drain();

    // back-pressure until every position is full
    grant_mode = 2;
    step();
    repeat (10) send_random_op();
    @(negedge clock);
    assert (!issue_ready) else begin
      $display("Issue stayed ready with the pipeline full and the grant withheld");
      report_failure();
    end
    grant_mode = 0;
    step();
    @(negedge clock);
    assert (issue_ready) else begin
      $display("Issue did not recover after the grant returned");
      report_failure();
    end
    step();
    grant_mode = 1;
    repeat (40) send_random_op();
    grant_mode = 0;
    drain();

    // rollback across the tag wrap, entries stacked behind a withheld grant
    grant_mode = 2;
    rob_next = 5'd29;
    repeat (10) send_random_op();
    do_rollback(5'd0, 5'd6);
    grant_mode = 0;
    drain();

    // rollback while entries flow
    grant_mode = 1;
    repeat (5) send_random_op();
    do_rollback(rob_next - 5'd3, rob_next - 5'd1);
    grant_mode = 0;
    drain();

    // rollback that empties the unit, held result included
    grant_mode = 2;
    repeat (3) send_random_op();
    while (!done) step();
    do_rollback(rob_next - 5'd3, rob_next - 5'd1);
    grant_mode = 0;
    drain();

    if (exp_q.size() == 0 && !done) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("Results still pending at the end of the run");
      report_failure();
    end
  end

endmodule
